// ==== verilog/mac_ctrl_pkg.sv ====
// widths, counter typedefs, stat input structs, counter records and link state enums
package mac_ctrl_pkg;

    // accumulator and event counter widths
    localparam int cnt_w = 32;
    localparam int err_w = 16;

    // per-cycle increment widths as delivered by the mac core
    localparam int rx_tot_bytes_w = 7;
    localparam int rx_pkts_w      = 3;
    localparam int good_bytes_w   = 14;   // shared by rx and tx
    localparam int tx_tot_bytes_w = 6;
    localparam int code_err_w     = 3;    // bad code and bad fcs

    typedef logic [cnt_w-1:0] count_t;      // packet or byte total
    typedef logic [err_w-1:0] err_count_t;  // event count

    // rx statistics, one increment per cycle
    typedef struct packed {
        logic [rx_tot_bytes_w-1:0] total_bytes;
        logic [good_bytes_w-1:0]   good_bytes;
        logic                      good_packets;
        logic [rx_pkts_w-1:0]      total_packets;
    } rx_stat_t;

    // rx error flags, nonzero means one event this cycle
    typedef struct packed {
        logic                  aligned_err;
        logic [code_err_w-1:0] bad_code;
        logic [code_err_w-1:0] bad_fcs;
        logic                  bad_preamble;
        logic                  bad_sfd;
    } rx_err_t;

    typedef struct packed {
        logic [tx_tot_bytes_w-1:0] total_bytes;
        logic [good_bytes_w-1:0]   good_bytes;
        logic                      good_packets;
        logic                      total_packets;
        logic                      ovf;           // tx fifo overflow
        logic                      unf;           // tx fifo underflow
    } tx_stat_t;

    typedef struct packed {
        count_t     good_packets;
        count_t     total_packets;
        count_t     good_bytes;
        count_t     total_bytes;
        err_count_t align_errors;
        err_count_t code_errors;
        err_count_t fcs_errors;
        err_count_t preamble_errors;
        err_count_t sfd_errors;
    } rx_counts_t;

    typedef struct packed {
        count_t     good_packets;
        count_t     total_packets;
        count_t     good_bytes;
        count_t     total_bytes;
        err_count_t overflow_count;
        err_count_t underflow_count;
    } tx_counts_t;

    // frozen copy handed to the host
    typedef struct packed {
        rx_counts_t rx;
        tx_counts_t tx;
        count_t     rx_bad_packets;   // total minus good at capture
    } stat_snap_t;

    typedef enum logic [1:0] {
        rx_idle, rx_gt_locked, rx_wait_aligned, rx_transfer
    } rx_link_state_t;

    typedef enum logic [1:0] {
        tx_idle, tx_gt_locked, tx_wait_aligned, tx_transfer
    } tx_link_state_t;

endpackage

// ==== verilog/link_bringup.sv ====
// rx and tx link bring-up state machines driving the mac control strobes
`timescale 1ns/100ps

module link_bringup (
    input  logic gt_txusrclk2,
    input  logic usr_rx_reset_w,
    input  logic stat_rx_aligned,
    output logic ctl_rx_enable,
    output logic ctl_tx_enable,
    output logic ctl_tx_send_lfi,
    output logic ctl_tx_send_rfi
);

    logic reset_done;   // first edge out of reset seen
    logic aligned_d;    // stat_rx_aligned, one flop

    mac_ctrl_pkg::rx_link_state_t rx_state;
    mac_ctrl_pkg::tx_link_state_t tx_state;

    // shared by both machines
    always_ff @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            reset_done <= 1'b0;
            aligned_d  <= 1'b0;
        end else begin
            reset_done <= 1'b1;
            aligned_d  <= stat_rx_aligned;
        end
    end

    // rx side: enable reception once core is out of reset
    always_ff @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            rx_state      <= mac_ctrl_pkg::rx_idle;
            ctl_rx_enable <= 1'b0;
        end else begin
            case (rx_state)
                mac_ctrl_pkg::rx_idle: begin
                    ctl_rx_enable <= 1'b0;
                    if (reset_done) rx_state <= mac_ctrl_pkg::rx_gt_locked;
                end
                mac_ctrl_pkg::rx_gt_locked: begin
                    ctl_rx_enable <= 1'b1;
                    rx_state      <= mac_ctrl_pkg::rx_wait_aligned;
                end
                mac_ctrl_pkg::rx_wait_aligned: begin
                    if (aligned_d) rx_state <= mac_ctrl_pkg::rx_transfer;
                end
                mac_ctrl_pkg::rx_transfer: begin
                    // lost lanes, restart bring-up
                    if (!aligned_d) rx_state <= mac_ctrl_pkg::rx_idle;
                end
                default: rx_state <= mac_ctrl_pkg::rx_idle;
            endcase
        end
    end

    // tx side: local and remote fault until rx is aligned
    always_ff @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            tx_state        <= mac_ctrl_pkg::tx_idle;
            ctl_tx_enable   <= 1'b0;
            ctl_tx_send_lfi <= 1'b0;
            ctl_tx_send_rfi <= 1'b0;
        end else begin
            case (tx_state)
                mac_ctrl_pkg::tx_idle: begin
                    ctl_tx_enable   <= 1'b0;
                    ctl_tx_send_lfi <= 1'b0;
                    ctl_tx_send_rfi <= 1'b0;
                    if (reset_done) tx_state <= mac_ctrl_pkg::tx_gt_locked;
                end
                mac_ctrl_pkg::tx_gt_locked: begin
                    ctl_tx_enable   <= 1'b0;
                    ctl_tx_send_lfi <= 1'b1;   // tell far end we are not up
                    ctl_tx_send_rfi <= 1'b1;
                    tx_state        <= mac_ctrl_pkg::tx_wait_aligned;
                end
                mac_ctrl_pkg::tx_wait_aligned: begin
                    if (aligned_d) tx_state <= mac_ctrl_pkg::tx_transfer;
                end
                mac_ctrl_pkg::tx_transfer: begin
                    ctl_tx_send_lfi <= 1'b0;
                    ctl_tx_send_rfi <= 1'b0;
                    ctl_tx_enable   <= 1'b1;
                    // outputs cleared one edge later, in idle
                    if (!aligned_d) tx_state <= mac_ctrl_pkg::tx_idle;
                end
                default: tx_state <= mac_ctrl_pkg::tx_idle;
            endcase
        end
    end

    // transmit never enabled while still signalling a local fault
    tx_en_vs_lfi: assert property (@(posedge gt_txusrclk2) disable iff (usr_rx_reset_w)
        !(ctl_tx_enable && ctl_tx_send_lfi));

endmodule

// ==== verilog/rx_stat_accum.sv ====
// rx packet and byte totals plus rx error event counters
`timescale 1ns/100ps

module rx_stat_accum (
    input  logic                     gt_txusrclk2,
    input  logic                     usr_rx_reset_w,
    input  mac_ctrl_pkg::rx_stat_t   rx_stat,
    input  mac_ctrl_pkg::rx_err_t    rx_err,
    output mac_ctrl_pkg::rx_counts_t rx_counts
);

    // totals, increments zero-extended to counter width
    always_ff @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            rx_counts.good_packets  <= '0;
            rx_counts.total_packets <= '0;
            rx_counts.good_bytes    <= '0;
            rx_counts.total_bytes   <= '0;
        end else begin
            rx_counts.good_packets  <= rx_counts.good_packets
                                     + mac_ctrl_pkg::count_t'(rx_stat.good_packets);
            rx_counts.total_packets <= rx_counts.total_packets
                                     + mac_ctrl_pkg::count_t'(rx_stat.total_packets);
            rx_counts.good_bytes    <= rx_counts.good_bytes
                                     + mac_ctrl_pkg::count_t'(rx_stat.good_bytes);
            rx_counts.total_bytes   <= rx_counts.total_bytes
                                     + mac_ctrl_pkg::count_t'(rx_stat.total_bytes);
        end
    end

    // error events, one count per cycle with the flag set
    // multi-bit fields count once no matter how many lanes flag
    always_ff @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            rx_counts.align_errors    <= '0;
            rx_counts.code_errors     <= '0;
            rx_counts.fcs_errors      <= '0;
            rx_counts.preamble_errors <= '0;
            rx_counts.sfd_errors      <= '0;
        end else begin
            if (rx_err.aligned_err) begin
                rx_counts.align_errors <= rx_counts.align_errors + 1'b1;
            end
            if (rx_err.bad_code != '0) begin
                rx_counts.code_errors <= rx_counts.code_errors + 1'b1;
            end
            if (rx_err.bad_fcs != '0) begin
                rx_counts.fcs_errors <= rx_counts.fcs_errors + 1'b1;
            end
            if (rx_err.bad_preamble) begin
                rx_counts.preamble_errors <= rx_counts.preamble_errors + 1'b1;
            end
            if (rx_err.bad_sfd) begin
                rx_counts.sfd_errors <= rx_counts.sfd_errors + 1'b1;
            end
        end
    end

    // running good total stays below running total, catches bad mac stats
    good_le_total: assert property (@(posedge gt_txusrclk2) disable iff (usr_rx_reset_w)
        rx_counts.good_packets <= rx_counts.total_packets);

endmodule

// ==== verilog/tx_stat_accum.sv ====
// tx packet and byte totals with overflow and underflow cycle counts
`timescale 1ns/100ps

module tx_stat_accum (
    input  logic                     gt_txusrclk2,
    input  logic                     usr_rx_reset_w,
    input  mac_ctrl_pkg::tx_stat_t   tx_stat,
    output mac_ctrl_pkg::tx_counts_t tx_counts
);

    always_ff @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            tx_counts <= '0;   // totals and both fifo counts
        end else begin
            tx_counts.good_packets  <= tx_counts.good_packets
                                     + mac_ctrl_pkg::count_t'(tx_stat.good_packets);
            tx_counts.total_packets <= tx_counts.total_packets
                                     + mac_ctrl_pkg::count_t'(tx_stat.total_packets);
            tx_counts.good_bytes    <= tx_counts.good_bytes
                                     + mac_ctrl_pkg::count_t'(tx_stat.good_bytes);
            tx_counts.total_bytes   <= tx_counts.total_bytes
                                     + mac_ctrl_pkg::count_t'(tx_stat.total_bytes);

            // cycles the tx fifo ran over
            if (tx_stat.ovf) begin
                tx_counts.overflow_count <= tx_counts.overflow_count + 1'b1;
            end
            // cycles it ran dry mid-packet
            if (tx_stat.unf) begin
                tx_counts.underflow_count <= tx_counts.underflow_count + 1'b1;
            end
        end
    end

endmodule

// ==== verilog/stat_snapshot.sv ====
// four-phase req/ack snapshot of rx and tx counters with derived bad-packet count
`timescale 1ns/100ps

module stat_snapshot (
    input  logic                     gt_txusrclk2,
    input  logic                     usr_rx_reset_w,
    input  mac_ctrl_pkg::rx_counts_t rx_counts,
    input  mac_ctrl_pkg::tx_counts_t tx_counts,
    input  logic                     snap_req,
    output logic                     snap_ack,
    output mac_ctrl_pkg::stat_snap_t snap
);

    logic capture;   // req seen, not yet acked

    assign capture = snap_req && !snap_ack;

    // handshake
    // req up, ack low  -> capture, raise ack
    // req down, ack up -> drop ack
    always_ff @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            snap_ack <= 1'b0;
        end else if (capture) begin
            snap_ack <= 1'b1;
        end else if (!snap_req && snap_ack) begin
            snap_ack <= 1'b0;
        end
    end

    // both records frozen on the same edge
    always_ff @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            snap <= '0;
        end else if (capture) begin
            snap.rx             <= rx_counts;
            snap.tx             <= tx_counts;
            snap.rx_bad_packets <= rx_counts.total_packets - rx_counts.good_packets;
        end
    end

    // ack only in answer to a request
    ack_needs_req: assert property (@(posedge gt_txusrclk2) disable iff (usr_rx_reset_w)
        $rose(snap_ack) |-> $past(snap_req));

    // host sees a frozen copy for the whole ack phase
    snap_frozen: assert property (@(posedge gt_txusrclk2) disable iff (usr_rx_reset_w)
        snap_ack |=> $stable(snap));

endmodule

// ==== verilog/mac_ctrl_top.sv ====
// top level: link bring-up, rx and tx stat accumulators and snapshot readout
`timescale 1ns/100ps

module mac_ctrl_top (
    input  logic                     gt_txusrclk2,
    input  logic                     usr_rx_reset_w,
    input  logic                     stat_rx_aligned,
    input  mac_ctrl_pkg::rx_stat_t   rx_stat,
    input  mac_ctrl_pkg::rx_err_t    rx_err,
    input  mac_ctrl_pkg::tx_stat_t   tx_stat,
    input  logic                     snap_req,
    output logic                     ctl_rx_enable,
    output logic                     ctl_tx_enable,
    output logic                     ctl_tx_send_lfi,
    output logic                     ctl_tx_send_rfi,
    output logic                     snap_ack,
    output mac_ctrl_pkg::stat_snap_t snap
);

    mac_ctrl_pkg::rx_counts_t rx_counts;   // live rx record
    mac_ctrl_pkg::tx_counts_t tx_counts;   // live tx record

    link_bringup u_link_bringup (
        .gt_txusrclk2    (gt_txusrclk2),
        .usr_rx_reset_w  (usr_rx_reset_w),
        .stat_rx_aligned (stat_rx_aligned),
        .ctl_rx_enable   (ctl_rx_enable),
        .ctl_tx_enable   (ctl_tx_enable),
        .ctl_tx_send_lfi (ctl_tx_send_lfi),
        .ctl_tx_send_rfi (ctl_tx_send_rfi)
    );

    rx_stat_accum u_rx_stat_accum (
        .gt_txusrclk2   (gt_txusrclk2),
        .usr_rx_reset_w (usr_rx_reset_w),
        .rx_stat        (rx_stat),
        .rx_err         (rx_err),
        .rx_counts      (rx_counts)
    );

    tx_stat_accum u_tx_stat_accum (
        .gt_txusrclk2   (gt_txusrclk2),
        .usr_rx_reset_w (usr_rx_reset_w),
        .tx_stat        (tx_stat),
        .tx_counts      (tx_counts)
    );

    stat_snapshot u_stat_snapshot (
        .gt_txusrclk2   (gt_txusrclk2),
        .usr_rx_reset_w (usr_rx_reset_w),
        .rx_counts      (rx_counts),
        .tx_counts      (tx_counts),
        .snap_req       (snap_req),
        .snap_ack       (snap_ack),
        .snap           (snap)
    );

endmodule

// ==== bench/mac_ctrl_tb.sv ====
// clock, reset, lfsr stimulus, reference model, snapshot compare and timeout for mac_ctrl_top
`timescale 1ns/100ps

module mac_ctrl_tb;

    localparam int reset_cycles   = 5;
    localparam int phase_cycles   = 500;   // one random counting phase
    localparam int num_phases     = 2;
    localparam int ack_wait_limit = 16;    // max cycles for each ack edge
    localparam int hold_cycles    = 4;     // req held high after ack while snap must stay frozen
    // twice the random phases plus room for bring-up and the handshake waits
    localparam int timeout_limit  = 2 * num_phases * phase_cycles + 500;

    logic                     gt_txusrclk2;
    logic                     usr_rx_reset_w;
    logic                     stat_rx_aligned;
    mac_ctrl_pkg::rx_stat_t   rx_stat;
    mac_ctrl_pkg::rx_err_t    rx_err;
    mac_ctrl_pkg::tx_stat_t   tx_stat;
    logic                     snap_req;
    logic                     ctl_rx_enable;
    logic                     ctl_tx_enable;
    logic                     ctl_tx_send_lfi;
    logic                     ctl_tx_send_rfi;
    logic                     snap_ack;
    mac_ctrl_pkg::stat_snap_t snap;

    mac_ctrl_pkg::stat_snap_t ref_snap;       // running model of the live counters
    mac_ctrl_pkg::stat_snap_t expected_snap;  // model frozen at request time
    logic                     compare_en;     // compare process active
    logic [15:0]              lfsr;
    int                       value_errors;
    int                       other_errors;
    int                       cycle_count;

    mac_ctrl_top UUT (
        .gt_txusrclk2    (gt_txusrclk2),
        .usr_rx_reset_w  (usr_rx_reset_w),
        .stat_rx_aligned (stat_rx_aligned),
        .rx_stat         (rx_stat),
        .rx_err          (rx_err),
        .tx_stat         (tx_stat),
        .snap_req        (snap_req),
        .ctl_rx_enable   (ctl_rx_enable),
        .ctl_tx_enable   (ctl_tx_enable),
        .ctl_tx_send_lfi (ctl_tx_send_lfi),
        .ctl_tx_send_rfi (ctl_tx_send_rfi),
        .snap_ack        (snap_ack),
        .snap            (snap)
    );

    always #50 gt_txusrclk2 = ~gt_txusrclk2;   // 100 ns period

    // 16-bit fibonacci lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per bit with msb first
    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    // every increment lands in the totals and each nonzero error field counts once
    function automatic mac_ctrl_pkg::stat_snap_t accumulate_expected(
        input mac_ctrl_pkg::stat_snap_t cur,
        input mac_ctrl_pkg::rx_stat_t   rs,
        input mac_ctrl_pkg::rx_err_t    re,
        input mac_ctrl_pkg::tx_stat_t   ts
    );
        mac_ctrl_pkg::stat_snap_t nxt;
        nxt = cur;
        nxt.rx.good_packets    = cur.rx.good_packets + rs.good_packets;
        nxt.rx.total_packets   = cur.rx.total_packets + rs.total_packets;
        nxt.rx.good_bytes      = cur.rx.good_bytes + rs.good_bytes;
        nxt.rx.total_bytes     = cur.rx.total_bytes + rs.total_bytes;
        nxt.rx.align_errors    = cur.rx.align_errors + (re.aligned_err ? 1 : 0);
        nxt.rx.code_errors     = cur.rx.code_errors + ((re.bad_code != 0) ? 1 : 0);
        nxt.rx.fcs_errors      = cur.rx.fcs_errors + ((re.bad_fcs != 0) ? 1 : 0);
        nxt.rx.preamble_errors = cur.rx.preamble_errors + (re.bad_preamble ? 1 : 0);
        nxt.rx.sfd_errors      = cur.rx.sfd_errors + (re.bad_sfd ? 1 : 0);
        nxt.tx.good_packets    = cur.tx.good_packets + ts.good_packets;
        nxt.tx.total_packets   = cur.tx.total_packets + ts.total_packets;
        nxt.tx.good_bytes      = cur.tx.good_bytes + ts.good_bytes;
        nxt.tx.total_bytes     = cur.tx.total_bytes + ts.total_bytes;
        nxt.tx.overflow_count  = cur.tx.overflow_count + (ts.ovf ? 1 : 0);
        nxt.tx.underflow_count = cur.tx.underflow_count + (ts.unf ? 1 : 0);
        nxt.rx_bad_packets     = nxt.rx.total_packets - nxt.rx.good_packets;
        return nxt;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            value_errors++;
            $display("[ERROR] %0t ns %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    task automatic check_ctl_outputs(input logic rx_en, input logic tx_en,
                                     input logic lfi, input logic rfi);
        check_value("ctl_rx_enable", rx_en, ctl_rx_enable);
        check_value("ctl_tx_enable", tx_en, ctl_tx_enable);
        check_value("ctl_tx_send_lfi", lfi, ctl_tx_send_lfi);
        check_value("ctl_tx_send_rfi", rfi, ctl_tx_send_rfi);
    endtask

    task automatic compare_snap(input mac_ctrl_pkg::stat_snap_t exp);
        check_value("snap.rx.good_packets", exp.rx.good_packets, snap.rx.good_packets);
        check_value("snap.rx.total_packets", exp.rx.total_packets, snap.rx.total_packets);
        check_value("snap.rx.good_bytes", exp.rx.good_bytes, snap.rx.good_bytes);
        check_value("snap.rx.total_bytes", exp.rx.total_bytes, snap.rx.total_bytes);
        check_value("snap.rx.align_errors", exp.rx.align_errors, snap.rx.align_errors);
        check_value("snap.rx.code_errors", exp.rx.code_errors, snap.rx.code_errors);
        check_value("snap.rx.fcs_errors", exp.rx.fcs_errors, snap.rx.fcs_errors);
        check_value("snap.rx.preamble_errors", exp.rx.preamble_errors,
                    snap.rx.preamble_errors);
        check_value("snap.rx.sfd_errors", exp.rx.sfd_errors, snap.rx.sfd_errors);
        check_value("snap.tx.good_packets", exp.tx.good_packets, snap.tx.good_packets);
        check_value("snap.tx.total_packets", exp.tx.total_packets, snap.tx.total_packets);
        check_value("snap.tx.good_bytes", exp.tx.good_bytes, snap.tx.good_bytes);
        check_value("snap.tx.total_bytes", exp.tx.total_bytes, snap.tx.total_bytes);
        check_value("snap.tx.overflow_count", exp.tx.overflow_count, snap.tx.overflow_count);
        check_value("snap.tx.underflow_count", exp.tx.underflow_count,
                    snap.tx.underflow_count);
        check_value("snap.rx_bad_packets", exp.rx_bad_packets, snap.rx_bad_packets);
    endtask

    // one clock with inputs changed 10 ns after the edge
    task automatic drive_step(input bit random_on);
        mac_ctrl_pkg::rx_stat_t rs;
        mac_ctrl_pkg::rx_err_t  re;
        mac_ctrl_pkg::tx_stat_t ts;
        logic [31:0]            v;
        @(posedge gt_txusrclk2);
        #10;
        rs = '0;
        re = '0;
        ts = '0;
        if (random_on) begin
            draw_bits(mac_ctrl_pkg::rx_tot_bytes_w, v);
            rs.total_bytes = v[mac_ctrl_pkg::rx_tot_bytes_w-1:0];
            draw_bits(mac_ctrl_pkg::good_bytes_w, v);
            rs.good_bytes = v[mac_ctrl_pkg::good_bytes_w-1:0];
            draw_bits(mac_ctrl_pkg::rx_pkts_w, v);
            rs.total_packets = v[mac_ctrl_pkg::rx_pkts_w-1:0];
            draw_bits(1, v);
            rs.good_packets = v[0] && (rs.total_packets != 0);   // good never above total
            draw_bits($bits(re), v);
            re = v[$bits(re)-1:0];
            draw_bits(mac_ctrl_pkg::tx_tot_bytes_w, v);
            ts.total_bytes = v[mac_ctrl_pkg::tx_tot_bytes_w-1:0];
            draw_bits(mac_ctrl_pkg::good_bytes_w, v);
            ts.good_bytes = v[mac_ctrl_pkg::good_bytes_w-1:0];
            draw_bits(4, v);
            ts.total_packets = v[3];
            ts.good_packets  = v[2] & v[3];
            ts.ovf           = v[1];
            ts.unf           = v[0];
        end
        rx_stat  = rs;
        rx_err   = re;
        tx_stat  = ts;
        ref_snap = accumulate_expected(ref_snap, rs, re, ts);
    endtask

    task automatic wait_for_ack(input logic level, input bit random_on);
        int n;
        n = 0;
        while (snap_ack !== level && n < ack_wait_limit) begin
            drive_step(random_on);
            n++;
        end
        if (snap_ack !== level) begin
            other_errors++;
            $display("snap_ack did not go to %0b within %0d cycles", level, ack_wait_limit);
        end
    endtask

    // two quiet cycles then one full four-phase handshake
    task automatic take_snapshot(input bit random_on);
        drive_step(1'b0);
        drive_step(1'b0);
        expected_snap = ref_snap;            // every increment driven so far
        check_value("snap_ack", 1'b0, snap_ack);
        snap_req = 1'b1;
        wait_for_ack(1'b1, random_on);
        compare_en = 1'b1;
        check_value("rx_bad_packets_derived",
                    expected_snap.rx.total_packets - expected_snap.rx.good_packets,
                    snap.rx_bad_packets);
        repeat (hold_cycles) drive_step(random_on);   // counters move but snap must not
        check_value("snap_ack", 1'b1, snap_ack);      // held while req stays high
        snap_req = 1'b0;
        wait_for_ack(1'b0, random_on);
        compare_en = 1'b0;
    endtask

    // compare process runs mid-cycle where snap is stable
    always @(negedge gt_txusrclk2) begin
        if (compare_en) compare_snap(expected_snap);
    end

    always @(posedge gt_txusrclk2) begin
        cycle_count++;
        if (cycle_count >= timeout_limit) begin
            other_errors++;
            $display("run stopped after %0d cycles without finishing the tests", cycle_count);
            $display("errors: %0d value mismatches, %0d other failures",
                     value_errors, other_errors);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        gt_txusrclk2    = 1'b0;
        usr_rx_reset_w  = 1'b1;
        stat_rx_aligned = 1'b0;
        rx_stat         = '0;
        rx_err          = '0;
        tx_stat         = '0;
        snap_req        = 1'b0;
        ref_snap        = '0;
        expected_snap   = '0;
        compare_en      = 1'b0;
        lfsr            = 16'd51;
        value_errors    = 0;
        other_errors    = 0;
        cycle_count     = 0;

        repeat (reset_cycles) begin
            drive_step(1'b0);
            check_ctl_outputs(1'b0, 1'b0, 1'b0, 1'b0);
            check_value("snap_ack", 1'b0, snap_ack);
        end
        usr_rx_reset_w = 1'b0;
        drive_step(1'b0);
        check_ctl_outputs(1'b0, 1'b0, 1'b0, 1'b0);   // first edge after release still quiet
        repeat (2) drive_step(1'b0);
        check_ctl_outputs(1'b1, 1'b0, 1'b1, 1'b1);   // waiting for alignment

        take_snapshot(1'b0);   // nothing counted yet so all zero

        stat_rx_aligned = 1'b1;
        repeat (2) drive_step(1'b0);
        check_ctl_outputs(1'b1, 1'b0, 1'b1, 1'b1);
        drive_step(1'b0);
        check_ctl_outputs(1'b1, 1'b1, 1'b0, 1'b0);   // transmit up on third edge

        stat_rx_aligned = 1'b0;                       // lanes lost
        repeat (3) drive_step(1'b0);
        check_ctl_outputs(1'b0, 1'b0, 1'b0, 1'b0);   // both machines back in idle
        repeat (2) drive_step(1'b0);
        check_ctl_outputs(1'b1, 1'b0, 1'b1, 1'b1);   // back to fault signalling

        stat_rx_aligned = 1'b1;
        repeat (phase_cycles) drive_step(1'b1);
        take_snapshot(1'b1);
        repeat (phase_cycles) drive_step(1'b1);
        take_snapshot(1'b1);

        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
verilog/mac_ctrl_pkg.sv
verilog/link_bringup.sv
verilog/rx_stat_accum.sv
verilog/tx_stat_accum.sv
verilog/stat_snapshot.sv
verilog/mac_ctrl_top.sv
bench/mac_ctrl_tb.sv
